/* logic/gl_config.svh */
`ifndef GL_CONFIG_SVH
`define GL_CONFIG_SVH

////////////////////////////////////////
// Operand memory
`define GL_MEM_WORDS    256
`define GL_ADDR_W       8

////////////////////////////////////////
// Matrix stacks and vertex output
`define GL_STACK_DEPTH  4
`define GL_VTX_CREDITS  4

// Viewport size after reset, Q16.16
`define GL_VIEWPORT_W   32'h0140_0000   // 320
`define GL_VIEWPORT_H   32'h00F0_0000   // 240

`endif

/* logic/gl_pkg.sv */
package gl_pkg;

    // Command opcodes
    typedef enum logic [7:0] {
        NOP           = 8'h00,
        VERTEX        = 8'h03,
        COLOR         = 8'h04,
        FLUSH         = 8'h05,
        MATRIX_MODE   = 8'h10,
        MULT_MATRIX   = 8'h11,
        LOAD_IDENTITY = 8'h12,
        LOAD_MATRIX   = 8'h13,
        PUSH_MATRIX   = 8'h14,
        POP_MATRIX    = 8'h15,
        VIEWPORT      = 8'h19
    } gl_opcode_t;

    // Matrix unit operations
    typedef enum logic [2:0] {
        MAT_LOAD_ID, MAT_LOAD, MAT_MULT, MAT_PUSH, MAT_POP, MAT_XFORM
    } gl_mat_op_t;

    typedef enum logic [1:0] {IDLE, FETCH, WAIT_MAT, EMIT} gl_dec_state_t;

    typedef enum logic {MODELVIEW = 1'b0, PROJECTION = 1'b1} gl_mat_mode_t;

    // Four Q16.16 words with x in [0] and w in [3]
    typedef logic [3:0][31:0] gl_vec4_t;

endpackage

/* logic/gl_mat_if.sv */
`timescale 1ns/1ps
`include "gl_config.svh"

interface gl_mat_if import gl_pkg::*; ();

    // Request, valid while start is high
    logic                  start;
    gl_mat_op_t            op;
    gl_mat_mode_t          mode;
    logic [`GL_ADDR_W-1:0] addr;     // First of 16 row-major words
    gl_vec4_t              vec_in;

    // Completion
    logic                  done;
    gl_vec4_t              vec_out;  // Transformed vertex, XFORM only

    modport decoder (
        output start, op, mode, addr, vec_in,
        input  done, vec_out
    );

    modport unit (
        input  start, op, mode, addr, vec_in,
        output done, vec_out
    );

endinterface

/* logic/gl_operand_mem.sv */
`timescale 1ns/1ps
`include "gl_config.svh"

module gl_operand_mem (
    input  logic                  clk,
    input  logic                  we,
    input  logic [`GL_ADDR_W-1:0] waddr,
    input  logic [31:0]           wdata,
    input  logic [`GL_ADDR_W-1:0] raddr_a,
    output logic [31:0]           rdata_a,
    input  logic [`GL_ADDR_W-1:0] raddr_b,
    output logic [31:0]           rdata_b
);

    logic [31:0] mem [`GL_MEM_WORDS];

    // Write from the command source, port A for the decoder, port B for the matrix unit
    always_ff @(posedge clk)
    begin
        if (we)
            mem[waddr] <= wdata;
        rdata_a <= mem[raddr_a];
        rdata_b <= mem[raddr_b];
    end

endmodule

/* logic/gl_matrix_unit.sv */
`timescale 1ns/1ps
`include "gl_config.svh"

module gl_matrix_unit import gl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    gl_mat_if.unit                mat,
    output logic [`GL_ADDR_W-1:0] mem_addr,
    input  logic [31:0]           mem_data
);

    localparam int          SP_W   = $clog2(`GL_STACK_DEPTH);
    localparam logic [31:0] FX_ONE = 32'h0001_0000;

    // Stack entry sp[m] is the current matrix of mode m
    logic [31:0]     stk [2][`GL_STACK_DEPTH][16];
    logic [SP_W-1:0] sp [2];
    logic [31:0]     scratch [16];   // Streamed MULT operand
    logic [31:0]     prod [16];      // C x M before it replaces C

    logic                  busy;
    gl_mat_op_t            op_q;
    gl_mat_mode_t          mode_q;
    logic [`GL_ADDR_W-1:0] addr_q;
    logic [1:0]            phase;    // MULT 0 stream, 1 MAC, 2 commit; XFORM 0 MV, 1 P
    logic [4:0]            cnt;
    logic [3:0]            widx;
    logic [3:0]            elem;
    logic [1:0]            k;
    logic [31:0]           acc;
    logic [31:0]           acc_next;
    logic [31:0]           mac_a;
    logic [31:0]           mac_b;
    logic [3:0]            a_idx;
    gl_mat_mode_t          src_mode;
    gl_vec4_t              vec;
    gl_vec4_t              res;

    function automatic logic [31:0] ident_word(input logic [3:0] idx);
        return (idx[3:2] == idx[1:0]) ? FX_ONE : 32'h0;
    endfunction

    // Q16.16 product, wraps
    function automatic logic [31:0] fx_mul(input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] p;
        p = $signed(a) * $signed(b);
        return p[47:16];
    endfunction

    assign mem_addr    = addr_q + `GL_ADDR_W'(cnt[3:0]);
    assign widx        = cnt[3:0] - 4'd1;   // Word returned this cycle
    assign mat.vec_out = res;

    ////////////////////////////////////////
    // One multiply-accumulate per cycle
    assign src_mode = (op_q == MAT_MULT) ? mode_q : (phase[0] ? PROJECTION : MODELVIEW);
    assign a_idx    = (op_q == MAT_MULT) ? {elem[3:2], k} : {elem[1:0], k};
    assign mac_a    = stk[src_mode][sp[src_mode]][a_idx];
    assign mac_b    = (op_q == MAT_MULT) ? scratch[{k, elem[1:0]}] : vec[k];
    assign acc_next = acc + fx_mul(mac_a, mac_b);

    always_ff @(posedge clk)
    begin
        mat.done <= 1'b0;
        if (rst)
        begin
            busy <= 1'b0;
            for (int m = 0; m < 2; m++)
            begin
                sp[m] <= '0;
                for (int i = 0; i < 16; i++)
                    stk[m][0][i] <= ident_word(4'(i));
            end
        end
        else if (mat.start)
        begin
            op_q   <= mat.op;
            mode_q <= mat.mode;
            addr_q <= mat.addr;
            vec    <= mat.vec_in;
            phase  <= 2'd0;
            cnt    <= '0;
            elem   <= '0;
            k      <= '0;
            acc    <= '0;
            case (mat.op)
                MAT_LOAD_ID:
                begin
                    for (int i = 0; i < 16; i++)
                        stk[mat.mode][sp[mat.mode]][i] <= ident_word(4'(i));
                    mat.done <= 1'b1;
                end
                MAT_PUSH:
                begin
                    if (sp[mat.mode] != SP_W'(`GL_STACK_DEPTH - 1))   // Full stack ignores push
                    begin
                        stk[mat.mode][sp[mat.mode] + 1'b1] <= stk[mat.mode][sp[mat.mode]];
                        sp[mat.mode] <= sp[mat.mode] + 1'b1;
                    end
                    mat.done <= 1'b1;
                end
                MAT_POP:
                begin
                    if (sp[mat.mode] != '0)
                        sp[mat.mode] <= sp[mat.mode] - 1'b1;
                    mat.done <= 1'b1;
                end
                default:
                    busy <= 1'b1;
            endcase
        end
        else if (busy)
        begin
            if (op_q == MAT_XFORM || phase == 2'd1)
            begin
                k   <= k + 1'b1;
                acc <= acc_next;
                if (k == 2'd3)   // Element finished
                begin
                    acc  <= '0;
                    elem <= elem + 1'b1;
                    if (op_q == MAT_MULT)
                    begin
                        prod[elem] <= acc_next;
                        if (elem == 4'd15)
                            phase <= 2'd2;
                    end
                    else
                    begin
                        res[elem[1:0]] <= acc_next;
                        if (elem[1:0] == 2'd3 && phase == 2'd0)
                        begin
                            // Modelview result feeds the projection pass
                            vec    <= res;
                            vec[3] <= acc_next;
                            phase  <= 2'd1;
                            elem   <= '0;
                        end
                        else if (elem[1:0] == 2'd3)
                        begin
                            busy     <= 1'b0;
                            mat.done <= 1'b1;
                        end
                    end
                end
            end
            else if (phase == 2'd2)
            begin
                stk[mode_q][sp[mode_q]] <= prod;
                busy     <= 1'b0;
                mat.done <= 1'b1;
            end
            else
            begin
                // Streaming, data lags the address by one cycle
                cnt <= cnt + 1'b1;
                if (cnt != '0 && op_q == MAT_LOAD)
                    stk[mode_q][sp[mode_q]][widx] <= mem_data;
                else if (cnt != '0)
                    scratch[widx] <= mem_data;
                if (cnt == 5'd16 && op_q == MAT_LOAD)
                begin
                    busy     <= 1'b0;
                    mat.done <= 1'b1;
                end
                else if (cnt == 5'd16)
                    phase <= 2'd1;
            end
        end
    end

endmodule

/* logic/gl_decode.sv */
`timescale 1ns/1ps
`include "gl_config.svh"

module gl_decode import gl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  gl_opcode_t            cmd_opcode,
    input  logic [22:0]           cmd_imm,
    input  logic [`GL_ADDR_W-1:0] cmd_addr,
    output logic [`GL_ADDR_W-1:0] mem_addr,
    input  logic [31:0]           mem_data,
    gl_mat_if.decoder             mat,
    output logic                  vtx_valid,
    output logic                  vtx_flush,
    output gl_vec4_t              vtx_data,
    input  logic                  vtx_credit,
    output logic [31:0]           color_r,
    output logic [31:0]           color_g,
    output logic [31:0]           color_b,
    output logic [31:0]           viewport_x,
    output logic [31:0]           viewport_y,
    output logic [31:0]           viewport_w,
    output logic [31:0]           viewport_h
);

    localparam int CRED_W = $clog2(`GL_VTX_CREDITS + 1);

    gl_dec_state_t         state;
    gl_opcode_t            op_q;
    logic [`GL_ADDR_W-1:0] addr_q;
    gl_mat_mode_t          mat_mode;       // Set by MATRIX_MODE
    logic                  accept;
    logic                  long_op;
    logic [2:0]            fetch_cnt;
    logic [2:0]            fetch_len;
    logic [1:0]            cap_idx;
    gl_vec4_t              opnd;           // Fetched operands, later the transformed vertex
    gl_vec4_t              fetch_vec;
    logic [CRED_W-1:0]     credits;

    assign cmd_ready = (state == IDLE);
    assign accept    = cmd_valid && cmd_ready;
    assign long_op   = (op_q == LOAD_MATRIX) || (op_q == MULT_MATRIX) || (op_q == VERTEX);

    ////////////////////////////////////////
    // Operand fetch through port A
    assign mem_addr  = addr_q + `GL_ADDR_W'(fetch_cnt);
    assign fetch_len = (op_q == COLOR) ? 3'd3 : 3'd4;
    assign cap_idx   = 2'(fetch_cnt - 3'd1);

    always_comb
    begin
        fetch_vec          = opnd;
        fetch_vec[cap_idx] = mem_data;   // Word addressed last cycle
    end

    // Matrix request fields, held from the command latch
    assign mat.mode   = mat_mode;
    assign mat.addr   = addr_q;
    assign mat.vec_in = opnd;

    always_comb
    begin
        case (op_q)
            LOAD_IDENTITY: mat.op = MAT_LOAD_ID;
            LOAD_MATRIX:   mat.op = MAT_LOAD;
            MULT_MATRIX:   mat.op = MAT_MULT;
            PUSH_MATRIX:   mat.op = MAT_PUSH;
            POP_MATRIX:    mat.op = MAT_POP;
            default:       mat.op = MAT_XFORM;   // VERTEX
        endcase
    end

    ////////////////////////////////////////
    // Command FSM
    always_ff @(posedge clk)
    begin
        mat.start <= 1'b0;
        vtx_valid <= 1'b0;
        vtx_flush <= 1'b0;
        if (rst)
        begin
            state      <= IDLE;
            op_q       <= NOP;
            mat_mode   <= MODELVIEW;
            fetch_cnt  <= '0;
            credits    <= CRED_W'(`GL_VTX_CREDITS);
            color_r    <= '0;
            color_g    <= '0;
            color_b    <= '0;
            viewport_x <= '0;
            viewport_y <= '0;
            viewport_w <= `GL_VIEWPORT_W;
            viewport_h <= `GL_VIEWPORT_H;
        end
        else
        begin
            credits <= credits + CRED_W'(vtx_credit) - CRED_W'(vtx_valid);
            case (state)
                IDLE:
                if (accept)
                begin
                    op_q      <= cmd_opcode;
                    addr_q    <= cmd_addr;
                    fetch_cnt <= '0;
                    case (cmd_opcode)
                        COLOR, VIEWPORT, VERTEX:
                            state <= FETCH;
                        LOAD_MATRIX, MULT_MATRIX, LOAD_IDENTITY, PUSH_MATRIX, POP_MATRIX:
                        begin
                            mat.start <= 1'b1;
                            state     <= WAIT_MAT;
                        end
                        FLUSH:
                            state <= EMIT;
                        MATRIX_MODE:
                        begin
                            mat_mode <= gl_mat_mode_t'(cmd_imm[0]);
                            state    <= WAIT_MAT;
                        end
                        default:
                            state <= WAIT_MAT;   // NOP, one cycle busy
                    endcase
                end
                FETCH:
                begin
                    fetch_cnt <= fetch_cnt + 1'b1;
                    if (fetch_cnt != '0)
                        opnd <= fetch_vec;
                    if (fetch_cnt == fetch_len)
                    begin
                        state <= IDLE;
                        if (op_q == COLOR)
                        begin
                            color_r <= fetch_vec[0];
                            color_g <= fetch_vec[1];
                            color_b <= fetch_vec[2];
                        end
                        else if (op_q == VIEWPORT)
                        begin
                            viewport_x <= fetch_vec[0];
                            viewport_y <= fetch_vec[1];
                            viewport_w <= fetch_vec[2];
                            viewport_h <= fetch_vec[3];
                        end
                        else
                        begin
                            mat.start <= 1'b1;   // Vertex complete, transform it
                            state     <= WAIT_MAT;
                        end
                    end
                end
                WAIT_MAT:
                begin
                    // Short ops finish at the start edge, their done lands before any new start
                    if (!long_op)
                        state <= IDLE;
                    else if (mat.done && op_q == VERTEX)
                    begin
                        opnd  <= mat.vec_out;
                        state <= EMIT;
                    end
                    else if (mat.done)
                        state <= IDLE;
                end
                EMIT:
                if (credits != '0)   // Otherwise hold, cmd_ready stays low
                begin
                    vtx_valid <= 1'b1;
                    vtx_flush <= (op_q == FLUSH);
                    vtx_data  <= (op_q == FLUSH) ? '0 : opnd;
                    state     <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

/* logic/gl_geometry.sv */
`timescale 1ns/1ps
`include "gl_config.svh"

module gl_geometry import gl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // Commands
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  gl_opcode_t            cmd_opcode,
    input  logic [22:0]           cmd_imm,
    input  logic [`GL_ADDR_W-1:0] cmd_addr,
    // Operand memory load
    input  logic                  mem_we,
    input  logic [`GL_ADDR_W-1:0] mem_waddr,
    input  logic [31:0]           mem_wdata,
    // Vertex output, credit based
    output logic                  vtx_valid,
    output logic                  vtx_flush,
    output gl_vec4_t              vtx_data,
    input  logic                  vtx_credit,
    // Status
    output logic [31:0]           color_r,
    output logic [31:0]           color_g,
    output logic [31:0]           color_b,
    output logic [31:0]           viewport_x,
    output logic [31:0]           viewport_y,
    output logic [31:0]           viewport_w,
    output logic [31:0]           viewport_h
);

    logic [`GL_ADDR_W-1:0] dec_addr;
    logic [31:0]           dec_data;
    logic [`GL_ADDR_W-1:0] unit_addr;
    logic [31:0]           unit_data;

    gl_mat_if mat_bus ();

    gl_operand_mem u_mem (
        .clk     (clk),
        .we      (mem_we),
        .waddr   (mem_waddr),
        .wdata   (mem_wdata),
        .raddr_a (dec_addr),
        .rdata_a (dec_data),
        .raddr_b (unit_addr),
        .rdata_b (unit_data)
    );

    gl_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_opcode (cmd_opcode),
        .cmd_imm    (cmd_imm),
        .cmd_addr   (cmd_addr),
        .mem_addr   (dec_addr),
        .mem_data   (dec_data),
        .mat        (mat_bus.decoder),
        .vtx_valid  (vtx_valid),
        .vtx_flush  (vtx_flush),
        .vtx_data   (vtx_data),
        .vtx_credit (vtx_credit),
        .color_r    (color_r),
        .color_g    (color_g),
        .color_b    (color_b),
        .viewport_x (viewport_x),
        .viewport_y (viewport_y),
        .viewport_w (viewport_w),
        .viewport_h (viewport_h)
    );

    gl_matrix_unit u_matrix (
        .clk      (clk),
        .rst      (rst),
        .mat      (mat_bus.unit),
        .mem_addr (unit_addr),
        .mem_data (unit_data)
    );

endmodule

/* tb/gl_geometry_properties.sv */
`timescale 1ns/1ps
`include "gl_config.svh"

module gl_geometry_properties import gl_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        cmd_valid,
    input logic        cmd_ready,
    input gl_opcode_t  cmd_opcode,
    input logic        vtx_valid,
    input logic        vtx_flush,
    input logic        vtx_credit,
    input logic [31:0] color_r,
    input logic [31:0] color_g,
    input logic [31:0] color_b,
    input logic [31:0] viewport_x,
    input logic [31:0] viewport_y,
    input logic [31:0] viewport_w,
    input logic [31:0] viewport_h
);

    int prop_fails = 0;   // Count of failed assertions
    int outstanding;      // Items out, credit not yet back

    always_ff @(posedge clk)
    begin
        if (rst)
            outstanding <= 0;
        else
            outstanding <= outstanding + int'(vtx_valid) - int'(vtx_credit);
    end

    ////////////////////////////////////////
    // Reset and command handshake
    reset_values: assert property (@(posedge clk)
        $fell(rst) |-> cmd_ready && !vtx_valid && !vtx_flush
            && color_r == '0 && color_g == '0 && color_b == '0
            && viewport_x == '0 && viewport_y == '0
            && viewport_w == `GL_VIEWPORT_W && viewport_h == `GL_VIEWPORT_H)
    else
    begin
        prop_fails++;
        $error("Status or handshake outputs not at their reset values");
    end

    opcode_stable: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_opcode))
    else
    begin
        prop_fails++;
        $error("Command dropped or changed while it waited for cmd_ready");
    end

    ////////////////////////////////////////
    // Vertex output credits
    valid_needs_credit: assert property (@(posedge clk) disable iff (rst)
        vtx_valid |-> outstanding < `GL_VTX_CREDITS)
    else
    begin
        prop_fails++;
        $error("vtx_valid high with no credit left");
    end

    outstanding_bound: assert property (@(posedge clk) disable iff (rst)
        outstanding >= 0 && outstanding <= `GL_VTX_CREDITS)
    else
    begin
        prop_fails++;
        $error("Outstanding output items out of the credit range");
    end

    flush_with_valid: assert property (@(posedge clk) disable iff (rst)
        vtx_flush |-> vtx_valid)
    else
    begin
        prop_fails++;
        $error("vtx_flush high without vtx_valid");
    end

endmodule

bind gl_geometry gl_geometry_properties props (.*);

/* tb/gl_geometry_tb.sv */
`timescale 1ns/1ps
`include "gl_config.svh"

module gl_geometry_tb import gl_pkg::*; ();

    localparam int TIMEOUT = 300;   // Cycles per wait

    logic                  clk;
    logic                  rst;
    logic                  cmd_valid;
    logic                  cmd_ready;
    gl_opcode_t            cmd_opcode;
    logic [22:0]           cmd_imm;
    logic [`GL_ADDR_W-1:0] cmd_addr;
    logic                  mem_we;
    logic [`GL_ADDR_W-1:0] mem_waddr;
    logic [31:0]           mem_wdata;
    logic                  vtx_valid;
    logic                  vtx_flush;
    gl_vec4_t              vtx_data;
    logic                  vtx_credit;
    logic [31:0]           color_r;
    logic [31:0]           color_g;
    logic [31:0]           color_b;
    logic [31:0]           viewport_x;
    logic [31:0]           viewport_y;
    logic [31:0]           viewport_w;
    logic [31:0]           viewport_h;

    // Reference model state
    logic [31:0] shadow [`GL_MEM_WORDS];   // Copy of the operand memory
    logic [31:0] stk [2][`GL_STACK_DEPTH][16];
    int          sp [2];
    int          mode;
    gl_vec4_t    exp_data [$];
    logic        exp_flush [$];
    logic [31:0] rng_state;

    int   errors;
    int   timeouts;
    int   checks;
    int   received;
    int   pending;      // Credits owed to the DUT
    int   held_base;
    logic hold;         // Consumer keeps its credits while set

    gl_geometry uut (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // Model arithmetic
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Random Q16.16 within about +-2.0
    function automatic logic [31:0] small_q();
        rng_state = xorshift(rng_state);
        return {{14{rng_state[17]}}, rng_state[17:0]};
    endfunction

    function automatic logic [31:0] fx_mul(input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] p;
        p = $signed(a) * $signed(b);
        return 32'(p >>> 16);
    endfunction

    function automatic gl_vec4_t mat_vec(input int m, input gl_vec4_t v);
        gl_vec4_t r;
        for (int i = 0; i < 4; i++)
        begin
            r[i] = '0;
            for (int j = 0; j < 4; j++)
                r[i] = r[i] + fx_mul(stk[m][sp[m]][4*i + j], v[j]);
        end
        return r;
    endfunction

    function automatic void set_identity(input int m);
        for (int i = 0; i < 16; i++)
            stk[m][sp[m]][i] = (i % 5 == 0) ? 32'h0001_0000 : '0;   // Diagonal
    endfunction

    // Current matrix C becomes C x M with M read row-major from base
    function automatic void mult_current(input logic [`GL_ADDR_W-1:0] base);
        logic [31:0] r [16];
        logic [31:0] m_kj;
        for (int i = 0; i < 4; i++)
            for (int j = 0; j < 4; j++)
            begin
                r[4*i + j] = '0;
                for (int k = 0; k < 4; k++)
                begin
                    m_kj = shadow[`GL_ADDR_W'(base + 4*k + j)];
                    r[4*i + j] = r[4*i + j] + fx_mul(stk[mode][sp[mode]][4*i + k], m_kj);
                end
            end
        for (int i = 0; i < 16; i++)
            stk[mode][sp[mode]][i] = r[i];
    endfunction

    function automatic void model_command(input gl_opcode_t op, input logic [22:0] imm,
                                          input logic [`GL_ADDR_W-1:0] addr);
        gl_vec4_t v;
        case (op)
            MATRIX_MODE:
                mode = int'(imm[0]);
            LOAD_IDENTITY:
                set_identity(mode);
            LOAD_MATRIX:
                for (int i = 0; i < 16; i++)
                    stk[mode][sp[mode]][i] = shadow[`GL_ADDR_W'(addr + i)];
            MULT_MATRIX:
                mult_current(addr);
            PUSH_MATRIX:
                if (sp[mode] < `GL_STACK_DEPTH - 1)   // Full stack stays as is
                begin
                    for (int i = 0; i < 16; i++)
                        stk[mode][sp[mode] + 1][i] = stk[mode][sp[mode]][i];
                    sp[mode]++;
                end
            POP_MATRIX:
                if (sp[mode] > 0)
                    sp[mode]--;
            VERTEX:
            begin
                for (int i = 0; i < 4; i++)
                    v[i] = shadow[`GL_ADDR_W'(addr + i)];
                exp_data.push_back(mat_vec(1, mat_vec(0, v)));   // P x (MV x v)
                exp_flush.push_back(1'b0);
            end
            FLUSH:
            begin
                exp_data.push_back('0);
                exp_flush.push_back(1'b1);
            end
            default:
                ;
        endcase
    endfunction

    ////////////////////////////////////////
    // Checking and ending the run
    task automatic expect_true(input logic ok, input string what);
        checks++;
        assert (ok)
        else
        begin
            errors++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    task automatic finish_run();
        int fails;
        fails = errors + timeouts + uut.props.prop_fails;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
                 checks, errors, uut.props.prop_fails, timeouts);
        if (fails == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    endtask

    task automatic abort_timeout(input string what);
        timeouts++;
        $display("Timed out waiting for %s.", what);
        finish_run();
    endtask

    ////////////////////////////////////////
    // Stimulus driven 1 ns after the clock edge
    task automatic wait_ready(input string what);
        int t;
        t = 0;
        while (!cmd_ready && t < TIMEOUT)
        begin
            @(posedge clk);
            #1;
            t++;
        end
        if (!cmd_ready)
            abort_timeout(what);
    endtask

    task automatic issue(input gl_opcode_t op, input logic [22:0] imm,
                         input logic [`GL_ADDR_W-1:0] addr);
        cmd_valid  = 1'b1;
        cmd_opcode = op;
        cmd_imm    = imm;
        cmd_addr   = addr;
        wait_ready($sformatf("acceptance of %s", op.name()));
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        model_command(op, imm, addr);
    endtask

    task automatic write_word(input logic [`GL_ADDR_W-1:0] addr, input logic [31:0] data);
        mem_we       = 1'b1;
        mem_waddr    = addr;
        mem_wdata    = data;
        shadow[addr] = data;
        @(posedge clk);
        #1;
        mem_we = 1'b0;
    endtask

    // Waits for the decoder first so no fetch reads a word mid-update
    task automatic fill_words(input logic [`GL_ADDR_W-1:0] base, input int n);
        wait_ready("an idle decoder");
        for (int i = 0; i < n; i++)
            write_word(`GL_ADDR_W'(base + i), small_q());
    endtask

    task automatic send_vertex(input logic [`GL_ADDR_W-1:0] base);
        fill_words(base, 4);
        issue(VERTEX, '0, base);
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while ((exp_data.size() != 0 || pending != 0) && t < TIMEOUT)
        begin
            @(posedge clk);
            #1;
            t++;
        end
        if (exp_data.size() != 0 || pending != 0)
            abort_timeout("the expected output items and their credits");
    endtask

    ////////////////////////////////////////
    // Consumer
    task automatic take_output();
        gl_vec4_t exp_v;
        logic     exp_f;
        received++;
        pending++;
        expect_true(exp_data.size() != 0, "output item with nothing expected");
        if (exp_data.size() != 0)
        begin
            exp_v = exp_data.pop_front();
            exp_f = exp_flush.pop_front();
            expect_true(vtx_flush == exp_f && (exp_f || vtx_data == exp_v),
                $sformatf("item %0d got flush %0b data %h, expected flush %0b data %h",
                          received, vtx_flush, vtx_data, exp_f, exp_v));
        end
    endtask

    initial
    begin
        vtx_credit = 1'b0;
        forever
        begin
            @(posedge clk);
            #1;
            if (vtx_valid)
                take_output();
            vtx_credit = (pending > 0) && !hold;   // One credit per cycle
            if (vtx_credit)
                pending--;
        end
    end

    ////////////////////////////////////////
    // Test sequence
    initial
    begin
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd_opcode = NOP;
        cmd_imm    = '0;
        cmd_addr   = '0;
        mem_we     = 1'b0;
        mem_waddr  = '0;
        mem_wdata  = '0;
        hold       = 1'b0;
        rng_state  = 32'hf61c13a6;
        mode       = 0;
        for (int m = 0; m < 2; m++)
        begin
            sp[m] = 0;
            set_identity(m);
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        expect_true(color_r == '0 && color_g == '0 && color_b == '0, "color after reset");
        expect_true(viewport_x == '0 && viewport_y == '0 && viewport_w == `GL_VIEWPORT_W
                    && viewport_h == `GL_VIEWPORT_H, "viewport after reset");
        expect_true(cmd_ready && !vtx_valid, "handshake after reset");

        // Status registers
        fill_words(8'h40, 3);
        issue(COLOR, '0, 8'h40);
        wait_ready("COLOR to finish");
        expect_true(color_r == shadow[8'h40] && color_g == shadow[8'h41]
                    && color_b == shadow[8'h42], "color registers after COLOR");
        fill_words(8'h48, 4);
        issue(VIEWPORT, '0, 8'h48);
        wait_ready("VIEWPORT to finish");
        expect_true(viewport_x == shadow[8'h48] && viewport_y == shadow[8'h49]
                    && viewport_w == shadow[8'h4a] && viewport_h == shadow[8'h4b],
                    "viewport registers after VIEWPORT");

        // Random projection and modelview
        fill_words(8'h10, 16);
        issue(MATRIX_MODE, 23'd1, '0);
        issue(LOAD_MATRIX, '0, 8'h10);
        fill_words(8'h00, 16);
        issue(MATRIX_MODE, 23'd0, '0);
        issue(MULT_MATRIX, '0, 8'h00);
        repeat (3) send_vertex(8'h80);
        wait_drained();

        // Push, multiply, pop
        issue(PUSH_MATRIX, '0, '0);
        fill_words(8'h20, 16);
        issue(MULT_MATRIX, '0, 8'h20);
        send_vertex(8'h80);
        issue(POP_MATRIX, '0, '0);
        send_vertex(8'h80);

        // Extra push and pop at the stack limits are no-ops
        repeat (`GL_STACK_DEPTH - 1) issue(PUSH_MATRIX, '0, '0);
        fill_words(8'h30, 16);
        issue(MULT_MATRIX, '0, 8'h30);
        issue(PUSH_MATRIX, '0, '0);
        send_vertex(8'h80);
        repeat (`GL_STACK_DEPTH) issue(POP_MATRIX, '0, '0);
        send_vertex(8'h80);
        wait_drained();

        // Identity in both modes passes the vertex through
        issue(MATRIX_MODE, 23'd1, '0);
        issue(LOAD_IDENTITY, '0, '0);
        issue(MATRIX_MODE, 23'd0, '0);
        issue(LOAD_IDENTITY, '0, '0);
        send_vertex(8'h80);
        wait_drained();

        // FLUSH stalls behind the held credits
        hold      = 1'b1;
        held_base = received;
        repeat (`GL_VTX_CREDITS) send_vertex(8'h80);
        issue(FLUSH, '0, '0);
        repeat (20) @(posedge clk);
        #1;
        expect_true(received == held_base + `GL_VTX_CREDITS, "items sent without credit");
        expect_true(!cmd_ready, "command input not stalled while out of credits");
        hold = 1'b0;
        send_vertex(8'h80);
        wait_drained();

        finish_run();
    end

endmodule

/* all.f */
+incdir+logic
logic/gl_pkg.sv
logic/gl_mat_if.sv
logic/gl_operand_mem.sv
logic/gl_matrix_unit.sv
logic/gl_decode.sv
logic/gl_geometry.sv
tb/gl_geometry_properties.sv
tb/gl_geometry_tb.sv

/* Bender.yml */
package:
  name: gl_geometry

sources:
  - include_dirs:
      - logic
    files:
      - logic/gl_pkg.sv
      - logic/gl_mat_if.sv
      - logic/gl_operand_mem.sv
      - logic/gl_matrix_unit.sv
      - logic/gl_decode.sv
      - logic/gl_geometry.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/gl_geometry_properties.sv
      - tb/gl_geometry_tb.sv
